// File: hdl/pl_pkg.sv
`default_nettype none

package pl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int ADDR_W   = 16;
  parameter int DATA_W   = 32;
  // low address bits that index a register inside one region
  parameter int REGION_W = 8;
  // default gpio line count
  parameter int GPIO_W   = 24;

  // region bases
  parameter logic [ADDR_W-1:0] GPIO_BASE = 16'h0000;
  parameter logic [ADDR_W-1:0] SPI_BASE  = 16'h0100;

  // gpio register offsets
  parameter logic [ADDR_W-1:0] REG_GPIO_DIR = 16'h0000;
  parameter logic [ADDR_W-1:0] REG_GPIO_OUT = 16'h0004;
  parameter logic [ADDR_W-1:0] REG_GPIO_IN  = 16'h0008;

  // spi register offsets
  parameter logic [ADDR_W-1:0] REG_SPI_CTRL = 16'h0000;
  parameter logic [ADDR_W-1:0] REG_SPI_TX   = 16'h0004;
  parameter logic [ADDR_W-1:0] REG_SPI_RX   = 16'h0008;
  parameter logic [ADDR_W-1:0] REG_SPI_STAT = 16'h000C;

  // request tracker in ps_system
  typedef enum logic [0:0] {BUS_IDLE, BUS_WAIT} bus_state_t;

  // spi shift engine
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_t;

endpackage

`default_nettype wire

// File: hdl/ps_system.sv
`default_nettype none

module ps_system
  import pl_pkg::*;
#(
  parameter int RST_CYCLES = 4
) (
  input  logic              clk,
  input  logic              rst_i,
  // external register bus
  input  logic [ADDR_W-1:0] sys_addr_i,
  input  logic [DATA_W-1:0] sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [DATA_W-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // fabric side
  output logic              fab_rst_o,
  output logic              gpio_sel_o,
  output logic              spi_sel_o,
  output logic [ADDR_W-1:0] reg_addr_o,
  output logic [DATA_W-1:0] reg_wdata_o,
  output logic              reg_wen_o,
  input  logic              gpio_ack_i,
  input  logic [DATA_W-1:0] gpio_rdata_i,
  input  logic              spi_ack_i,
  input  logic [DATA_W-1:0] spi_rdata_i
);

  localparam int CNT_W = $clog2(RST_CYCLES + 2);

  logic [CNT_W-1:0] rst_cnt_q;
  bus_state_t       state_q;
  // decode error, first stage
  logic             err_q;
  // second stage, lines up with a slave ack
  logic             err_d_q;
  logic             strobe;
  logic             hit_gpio;
  logic             hit_spi;

  //////////////////////////////////////////////////////////////////////////
  // fabric reset stretcher
  //////////////////////////////////////////////////////////////////////////

  // holds fab_rst_o for RST_CYCLES edges after rst_i drops
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rst_cnt_q <= CNT_W'(RST_CYCLES);
      fab_rst_o <= 1'b1;
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
      // last count releases the fabric
      fab_rst_o <= (rst_cnt_q != CNT_W'(1));
    end else begin
      fab_rst_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // request tracker and decode
  //////////////////////////////////////////////////////////////////////////

  assign strobe   = sys_wen_i | sys_ren_i;
  // region match on upper address bits
  assign hit_gpio = (sys_addr_i[ADDR_W-1:REGION_W] == GPIO_BASE[ADDR_W-1:REGION_W]);
  assign hit_spi  = (sys_addr_i[ADDR_W-1:REGION_W] == SPI_BASE[ADDR_W-1:REGION_W]);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= BUS_IDLE;
      gpio_sel_o <= 1'b0;
      spi_sel_o  <= 1'b0;
      err_q      <= 1'b0;
      err_d_q    <= 1'b0;
      sys_ack_o  <= 1'b0;
      sys_err_o  <= 1'b0;
    end else begin
      // selects and responses are single-cycle pulses
      gpio_sel_o <= 1'b0;
      spi_sel_o  <= 1'b0;
      err_q      <= 1'b0;
      err_d_q    <= err_q;
      sys_ack_o  <= 1'b0;
      sys_err_o  <= 1'b0;
      case (state_q)
        BUS_IDLE: begin
          if (strobe) begin
            state_q <= BUS_WAIT;
            // peripherals still held in reset, refuse
            if (fab_rst_o) begin
              err_q <= 1'b1;
            end else if (hit_gpio) begin
              gpio_sel_o <= 1'b1;
            end else if (hit_spi) begin
              spi_sel_o <= 1'b1;
            end else begin
              err_q <= 1'b1;
            end
          end
        end
        BUS_WAIT: begin
          // strobes here are dropped
          if (gpio_ack_i || spi_ack_i || err_d_q) begin
            state_q   <= BUS_IDLE;
            sys_ack_o <= gpio_ack_i | spi_ack_i;
            sys_err_o <= err_d_q;
          end
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  // request payload, offset within the region only
  always_ff @(posedge clk) begin
    if ((state_q == BUS_IDLE) && strobe) begin
      reg_addr_o  <= {{(ADDR_W-REGION_W){1'b0}}, sys_addr_i[REGION_W-1:0]};
      reg_wdata_o <= sys_wdata_i;
      reg_wen_o   <= sys_wen_i;
    end
    // response mux, zero on error
    sys_rdata_o <= gpio_ack_i ? gpio_rdata_i : (spi_ack_i ? spi_rdata_i : '0);
  end

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
`default_nettype none

module gpio_regs
  import pl_pkg::*;
#(
  parameter int GPIO_N = GPIO_W
) (
  input  logic              clk,
  input  logic              fab_rst_i,
  // register access from ps_system
  input  logic              sel_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              wen_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  // tristate pins
  input  logic [GPIO_N-1:0] gpio_tri_i,
  output logic [GPIO_N-1:0] gpio_tri_o,
  output logic [GPIO_N-1:0] gpio_tri_t
);

  // 1 = pin driven
  logic [GPIO_N-1:0] dir_q;
  logic [GPIO_N-1:0] out_q;
  // two-flop input synchronizer
  logic [GPIO_N-1:0] sync1_q;
  logic [GPIO_N-1:0] sync2_q;
  logic [DATA_W-1:0] rd_mux;

  //////////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fab_rst_i) begin
      dir_q <= '0;
      out_q <= '0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= sel_i;
      if (sel_i && wen_i) begin
        case (addr_i)
          REG_GPIO_DIR: dir_q <= wdata_i[GPIO_N-1:0];
          REG_GPIO_OUT: out_q <= wdata_i[GPIO_N-1:0];
          // input register is read only
          default: ;
        endcase
      end
    end
  end

  // pins are asynchronous to clk
  always_ff @(posedge clk) begin
    sync1_q <= gpio_tri_i;
    sync2_q <= sync1_q;
  end

  //////////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (addr_i)
      REG_GPIO_DIR: rd_mux = DATA_W'(dir_q);
      REG_GPIO_OUT: rd_mux = DATA_W'(out_q);
      REG_GPIO_IN:  rd_mux = DATA_W'(sync2_q);
      // unknown offset reads zero
      default:      rd_mux = '0;
    endcase
  end

  // read data lands together with ack
  always_ff @(posedge clk) begin
    rdata_o <= sel_i ? rd_mux : '0;
  end

  // pin drive
  assign gpio_tri_o = out_q;
  // enable is active low, inputs by default
  assign gpio_tri_t = ~dir_q;

endmodule

`default_nettype wire

// File: hdl/spi_regs.sv
`default_nettype none

module spi_regs
  import pl_pkg::*;
(
  input  logic              clk,
  input  logic              fab_rst_i,
  // register access from ps_system
  input  logic              sel_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              wen_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  // shift engine
  input  logic              busy_i,
  input  logic              done_i,
  input  logic [7:0]        rx_byte_i,
  output logic              start_o,
  output logic [7:0]        tx_byte_o,
  output logic [7:0]        clk_div_o,
  output logic              enable_o,
  output logic [1:0]        ss_sel_o
);

  logic [7:0]        rx_q;
  logic [DATA_W-1:0] rd_mux;

  //////////////////////////////////////////////////////////////////////////
  // control, transmit and receive
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fab_rst_i) begin
      ack_o     <= 1'b0;
      start_o   <= 1'b0;
      enable_o  <= 1'b0;
      ss_sel_o  <= 2'd0;
      clk_div_o <= 8'd0;
      tx_byte_o <= 8'd0;
    end else begin
      ack_o   <= sel_i;
      start_o <= 1'b0;
      if (sel_i && wen_i) begin
        case (addr_i)
          REG_SPI_CTRL: begin
            // en bit 0, ss bits 2:1, divider bits 15:8
            enable_o  <= wdata_i[0];
            ss_sel_o  <= wdata_i[2:1];
            clk_div_o <= wdata_i[15:8];
          end
          REG_SPI_TX: begin
            // running transfer keeps its byte
            if (!busy_i && !start_o) begin
              tx_byte_o <= wdata_i[7:0];
              start_o   <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // received byte, taken on done
  always_ff @(posedge clk) begin
    if (done_i) begin
      rx_q <= rx_byte_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (addr_i)
      REG_SPI_CTRL: rd_mux = {16'd0, clk_div_o, 5'd0, ss_sel_o, enable_o};
      REG_SPI_TX:   rd_mux = {24'd0, tx_byte_o};
      REG_SPI_RX:   rd_mux = {24'd0, rx_q};
      REG_SPI_STAT: rd_mux = {31'd0, busy_i};
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    rdata_o <= sel_i ? rd_mux : '0;
  end

endmodule

`default_nettype wire

// File: hdl/spi_master.sv
`default_nettype none

module spi_master
  import pl_pkg::*;
(
  input  logic       clk,
  input  logic       fab_rst_i,
  // from spi_regs
  input  logic       start_i,
  input  logic [7:0] tx_byte_i,
  input  logic [7:0] clk_div_i,
  input  logic       enable_i,
  input  logic [1:0] ss_sel_i,
  output logic       busy_o,
  output logic       done_o,
  output logic [7:0] rx_byte_o,
  // pins
  input  logic       spi_io1_i,
  output logic       spi_sck_o,
  output logic       spi_sck_t,
  output logic       spi_io0_o,
  output logic       spi_io0_t,
  output logic       spi_ss_o,
  output logic       spi_ss1_o,
  output logic       spi_ss2_o,
  output logic       spi_ss_t,
  output logic       spi_io1_o,
  output logic       spi_io1_t
);

  spi_state_t state_q;
  // divider latched at start
  logic [7:0] div_q;
  logic [7:0] cnt_q;
  // sck half periods done, 16 per byte
  logic [3:0] half_q;
  logic [7:0] tx_sh_q;
  logic       shifting;

  //////////////////////////////////////////////////////////////////////////
  // shift engine, mode 0
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fab_rst_i) begin
      state_q   <= SPI_IDLE;
      done_o    <= 1'b0;
      spi_sck_o <= 1'b0;
      tx_sh_q   <= 8'd0;
      cnt_q     <= 8'd0;
      half_q    <= 4'd0;
      div_q     <= 8'd0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          if (start_i && enable_i) begin
            state_q   <= SPI_SHIFT;
            div_q     <= clk_div_i;
            cnt_q     <= clk_div_i;
            half_q    <= 4'd0;
            spi_sck_o <= 1'b0;
            // msb goes out before the first rising edge
            tx_sh_q   <= tx_byte_i;
          end
        end
        SPI_SHIFT: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            cnt_q     <= div_q;
            half_q    <= half_q + 1'b1;
            spi_sck_o <= ~spi_sck_o;
            // falling edge, next bit out
            if (spi_sck_o) begin
              tx_sh_q <= {tx_sh_q[6:0], 1'b0};
            end
            if (half_q == 4'd15) begin
              state_q <= SPI_DONE;
              done_o  <= 1'b1;
            end
          end
        end
        // one cycle for the done pulse
        SPI_DONE: state_q <= SPI_IDLE;
        default:  state_q <= SPI_IDLE;
      endcase
    end
  end

  // rising edge, miso in
  always_ff @(posedge clk) begin
    if (shifting && (cnt_q == 8'd0) && !spi_sck_o) begin
      rx_byte_o <= {rx_byte_o[6:0], spi_io1_i};
    end
  end

  assign shifting  = (state_q == SPI_SHIFT);
  assign busy_o    = (state_q != SPI_IDLE);
  assign spi_io0_o = tx_sh_q[7];

  // active-low selects, low outputs while disabled
  assign spi_ss_o  = enable_i & ~(shifting && (ss_sel_i == 2'd0));
  assign spi_ss1_o = enable_i & ~(shifting && (ss_sel_i == 2'd1));
  assign spi_ss2_o = enable_i & ~(shifting && (ss_sel_i == 2'd2));

  // drivers on only while enabled
  assign spi_sck_t = ~enable_i;
  assign spi_io0_t = ~enable_i;
  assign spi_ss_t  = ~enable_i;
  // io1 is miso, never driven
  assign spi_io1_o = 1'b0;
  assign spi_io1_t = 1'b1;

endmodule

`default_nettype wire

// File: hdl/pl_top.sv
`default_nettype none

module pl_top
  import pl_pkg::*;
#(
  parameter int RST_CYCLES = 4,
  parameter int GPIO_N     = GPIO_W
) (
  input  logic              clk,
  input  logic              rst_i,
  // register bus
  input  logic [ADDR_W-1:0] sys_addr_i,
  input  logic [DATA_W-1:0] sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [DATA_W-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // gpio pins
  input  logic [GPIO_N-1:0] gpio_tri_i,
  output logic [GPIO_N-1:0] gpio_tri_o,
  output logic [GPIO_N-1:0] gpio_tri_t,
  // spi pins
  input  logic              spi_io1_i,
  output logic              spi_sck_o,
  output logic              spi_sck_t,
  output logic              spi_io0_o,
  output logic              spi_io0_t,
  output logic              spi_ss_o,
  output logic              spi_ss1_o,
  output logic              spi_ss2_o,
  output logic              spi_ss_t,
  output logic              spi_io1_o,
  output logic              spi_io1_t
);

  logic              fab_rst;
  logic              gpio_sel;
  logic              spi_sel;
  logic [ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0] reg_wdata;
  logic              reg_wen;
  logic              gpio_ack;
  logic [DATA_W-1:0] gpio_rdata;
  logic              spi_ack;
  logic [DATA_W-1:0] spi_rdata;
  // regs to shift engine
  logic              spi_start;
  logic [7:0]        spi_tx_byte;
  logic [7:0]        spi_clk_div;
  logic              spi_enable;
  logic [1:0]        spi_ss_sel;
  logic              spi_busy;
  logic              spi_done;
  logic [7:0]        spi_rx_byte;

  ps_system #(.RST_CYCLES(RST_CYCLES)) u_ps (
    .clk(clk), .rst_i(rst_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i),
    .sys_wen_i(sys_wen_i), .sys_ren_i(sys_ren_i),
    .sys_rdata_o(sys_rdata_o), .sys_ack_o(sys_ack_o), .sys_err_o(sys_err_o),
    .fab_rst_o(fab_rst), .gpio_sel_o(gpio_sel), .spi_sel_o(spi_sel),
    .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata), .reg_wen_o(reg_wen),
    .gpio_ack_i(gpio_ack), .gpio_rdata_i(gpio_rdata),
    .spi_ack_i(spi_ack), .spi_rdata_i(spi_rdata)
  );

  gpio_regs #(.GPIO_N(GPIO_N)) u_gpio (
    .clk(clk), .fab_rst_i(fab_rst),
    .sel_i(gpio_sel), .addr_i(reg_addr), .wdata_i(reg_wdata), .wen_i(reg_wen),
    .ack_o(gpio_ack), .rdata_o(gpio_rdata),
    .gpio_tri_i(gpio_tri_i), .gpio_tri_o(gpio_tri_o), .gpio_tri_t(gpio_tri_t)
  );

  spi_regs u_spi_regs (
    .clk(clk), .fab_rst_i(fab_rst),
    .sel_i(spi_sel), .addr_i(reg_addr), .wdata_i(reg_wdata), .wen_i(reg_wen),
    .ack_o(spi_ack), .rdata_o(spi_rdata),
    .busy_i(spi_busy), .done_i(spi_done), .rx_byte_i(spi_rx_byte),
    .start_o(spi_start), .tx_byte_o(spi_tx_byte), .clk_div_o(spi_clk_div),
    .enable_o(spi_enable), .ss_sel_o(spi_ss_sel)
  );

  spi_master u_spi (
    .clk(clk), .fab_rst_i(fab_rst),
    .start_i(spi_start), .tx_byte_i(spi_tx_byte), .clk_div_i(spi_clk_div),
    .enable_i(spi_enable), .ss_sel_i(spi_ss_sel),
    .busy_o(spi_busy), .done_o(spi_done), .rx_byte_o(spi_rx_byte),
    .spi_io1_i(spi_io1_i), .spi_sck_o(spi_sck_o), .spi_sck_t(spi_sck_t),
    .spi_io0_o(spi_io0_o), .spi_io0_t(spi_io0_t),
    .spi_ss_o(spi_ss_o), .spi_ss1_o(spi_ss1_o), .spi_ss2_o(spi_ss2_o),
    .spi_ss_t(spi_ss_t), .spi_io1_o(spi_io1_o), .spi_io1_t(spi_io1_t)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 8,
  parameter int RST_LEN   = 16
) (
  output logic clk,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset held from time zero, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_LEN) @(negedge clk);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`default_nettype none

module tb_top
  import pl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES    = 4;
  localparam int GPIO_N        = GPIO_W;
  localparam int CLK_NS        = 8;
  localparam int RST_LEN       = 16;
  // cycles to wait for ack or err, and status reads per busy wait
  localparam int RESP_LIMIT    = 16;
  localparam int POLL_LIMIT    = 100;
  // response seen on the third falling edge after the strobe
  localparam int RESP_LAT      = 3;
  // one divider per byte lane, lane 0 first
  localparam logic [31:0] SPI_DIVS = 32'h07_03_01_00;
  localparam int N_DIVS        = 4;
  localparam int BYTES_PER_DIV = 2;
  localparam int BUSY_DIV      = 3;
  localparam int GPIO_ROUNDS   = 4;
  // accesses outside the spi transfers, upper bound
  localparam int BUS_OPS       = 64;

  // sum of all spi transfer lengths in clk cycles
  function automatic int spi_xfer_cycles();
    int total;
    total = 16 * (BUSY_DIV + 1);
    for (int k = 0; k < N_DIVS; k++) begin
      total += 16 * BYTES_PER_DIV * (int'(SPI_DIVS[8*k +: 8]) + 1);
    end
    return total;
  endfunction

  localparam int XFER_CYCLES = spi_xfer_cycles();
  // x4 margin over reset, transfers and bus traffic
  localparam int WATCHDOG_NS =
    4 * CLK_NS * (RST_LEN + RST_CYCLES + XFER_CYCLES + 8 * BUS_OPS);

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] sys_addr;
  logic [DATA_W-1:0] sys_wdata;
  logic              sys_wen;
  logic              sys_ren;
  logic [DATA_W-1:0] sys_rdata;
  logic              sys_ack;
  logic              sys_err;
  logic [GPIO_N-1:0] gpio_in;
  logic [GPIO_N-1:0] gpio_out;
  logic [GPIO_N-1:0] gpio_t;
  // value seen on undriven pins
  logic [GPIO_N-1:0] pin_pat;
  logic              spi_sck;
  logic              spi_sck_t;
  logic              spi_io0;
  logic              spi_io0_t;
  logic              spi_io1;
  logic              spi_io1_o;
  logic              spi_io1_t;
  logic              spi_ss;
  logic              spi_ss1;
  logic              spi_ss2;
  logic              spi_ss_t;

  logic [31:0]       rng_state;
  logic              tests_done;
  int                pass_cnt;
  int                fail_cnt;
  int                err_cnt;
  // rising edges seen on the sck pin
  int                sck_rises = 0;
  // pending checks, filled by the stimulus
  string             name_q[$];
  logic [31:0]       exp_q[$];
  logic [31:0]       act_q[$];

  tb_clock #(.PERIOD_NS(CLK_NS), .RST_LEN(RST_LEN)) u_clock (
    .clk(clk), .rst_o(rst)
  );

  pl_top #(.RST_CYCLES(RST_CYCLES), .GPIO_N(GPIO_N)) dut (
    .clk(clk), .rst_i(rst),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata),
    .sys_wen_i(sys_wen), .sys_ren_i(sys_ren),
    .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack), .sys_err_o(sys_err),
    .gpio_tri_i(gpio_in), .gpio_tri_o(gpio_out), .gpio_tri_t(gpio_t),
    .spi_io1_i(spi_io1), .spi_sck_o(spi_sck), .spi_sck_t(spi_sck_t),
    .spi_io0_o(spi_io0), .spi_io0_t(spi_io0_t),
    .spi_ss_o(spi_ss), .spi_ss1_o(spi_ss1), .spi_ss2_o(spi_ss2),
    .spi_ss_t(spi_ss_t), .spi_io1_o(spi_io1_o), .spi_io1_t(spi_io1_t)
  );

  // driven pins read back, released pins read the pattern
  assign gpio_in = (gpio_t & pin_pat) | (~gpio_t & gpio_out);
  // mosi straight into miso
  assign spi_io1 = spi_io0;

  // sck edge counter
  always @(posedge spi_sck) begin
    sck_rises++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and reference models
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // direction bit set -> own output, else whatever the pin carries
  function automatic logic [31:0] gpio_in_expect(input logic [GPIO_N-1:0] dir,
                                                 input logic [GPIO_N-1:0] out,
                                                 input logic [GPIO_N-1:0] pat);
    return 32'((dir & out) | (~dir & pat));
  endfunction

  // mode 0 loopback, each rising sck takes the bit on mosi, msb first
  function automatic logic [31:0] spi_rx_expect(input logic [7:0] tx);
    logic [7:0] rx;
    rx = 8'd0;
    for (int i = 7; i >= 0; i--) begin
      rx = {rx[6:0], tx[i]};
    end
    return {24'd0, rx};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic record(input string name, input logic [31:0] exp_v,
                        input logic [31:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  // one strobe, then wait for ack or err; lat counts falling edges
  task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic wr, output logic [DATA_W-1:0] rdata,
                            output logic ack, output logic err, output int lat);
    @(negedge clk);
    // previous response pulse is over by now
    assert (!sys_ack && !sys_err) else begin
      $display("ERROR: ack or err still high one cycle after the response");
      err_cnt++;
    end
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(negedge clk);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    lat     = 1;
    while (!sys_ack && !sys_err && lat < RESP_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    ack   = sys_ack;
    err   = sys_err;
    rdata = sys_rdata;
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused_rd;
    logic              ack;
    logic              err;
    int                lat;
    bus_access(addr, data, 1'b1, unused_rd, ack, err, lat);
    assert (ack && !err && lat == RESP_LAT) else begin
      $display("ERROR: write to 0x%04h got ack=%0b err=%0b after %0d cycles",
               addr, ack, err, lat);
      err_cnt++;
    end
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic ack;
    logic err;
    int   lat;
    bus_access(addr, '0, 1'b0, data, ack, err, lat);
    assert (ack && !err && lat == RESP_LAT) else begin
      $display("ERROR: read from 0x%04h got ack=%0b err=%0b after %0d cycles",
               addr, ack, err, lat);
      err_cnt++;
    end
  endtask

  // poll status until busy equals level
  task automatic wait_busy(input logic level);
    logic [DATA_W-1:0] stat;
    logic              reached;
    int                polls;
    reached = 1'b0;
    polls   = 0;
    while (!reached && polls < POLL_LIMIT) begin
      read_reg(SPI_BASE + REG_SPI_STAT, stat);
      reached = (stat[0] == level);
      polls++;
    end
    assert (reached) else begin
      $display("ERROR: spi busy did not go to %0b within %0d status reads", level, POLL_LIMIT);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic [31:0] dir;
    logic [31:0] out;
    logic [7:0]  div;
    logic [7:0]  tx_a;
    logic [7:0]  tx_b;
    logic [1:0]  ss;
    logic        ack;
    logic        err;
    int          lat;
    int          rises0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    pin_pat    = '0;
    rng_state  = 32'd9696;
    tests_done = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    err_cnt    = 0;
    @(posedge clk);
    wait (rst == 1'b0);

    // pin levels right after rst drops
    record("reset_gpio_tri_t", 32'({GPIO_N{1'b1}}), 32'(gpio_t));
    record("reset_gpio_tri_o", 32'd0, 32'(gpio_out));
    record("reset_spi_tri_t", 32'd7, 32'({spi_sck_t, spi_io0_t, spi_ss_t}));
    record("reset_spi_out", 32'd0, 32'({spi_sck, spi_io0, spi_ss, spi_ss1, spi_ss2}));
    // miso pin is never driven
    record("reset_spi_io1", 32'b10, 32'({spi_io1_t, spi_io1_o}));
    record("reset_ack_err", 32'd0, 32'({sys_ack, sys_err}));
    // fabric still held, expect err
    bus_access(GPIO_BASE + REG_GPIO_IN, '0, 1'b0, rdata, ack, err, lat);
    record("fab_reset_strobe_err", 32'b10, 32'({err, ack}));
    repeat (RST_CYCLES) @(negedge clk);

    // response timing, mapped and unmapped
    bus_access(GPIO_BASE + REG_GPIO_DIR, '0, 1'b0, rdata, ack, err, lat);
    record("mapped_read_ack", 32'b01, 32'({err, ack}));
    record("mapped_read_latency", 32'd3, 32'(lat));
    bus_access(16'h0200, '0, 1'b0, rdata, ack, err, lat);
    record("unmapped_read_err", 32'b10, 32'({err, ack}));
    record("unmapped_read_latency", 32'd3, 32'(lat));

    // gpio loopback
    for (int r = 0; r < GPIO_ROUNDS; r++) begin
      dir     = next_random();
      out     = next_random();
      rnd     = next_random();
      pin_pat = rnd[GPIO_N-1:0];
      write_reg(GPIO_BASE + REG_GPIO_DIR, dir);
      write_reg(GPIO_BASE + REG_GPIO_OUT, out);
      read_reg(GPIO_BASE + REG_GPIO_IN, rdata);
      record($sformatf("gpio_in_round%0d", r),
             gpio_in_expect(dir[GPIO_N-1:0], out[GPIO_N-1:0], rnd[GPIO_N-1:0]), rdata);
    end

    // spi loopback over every divider
    for (int k = 0; k < N_DIVS; k++) begin
      div = SPI_DIVS[8*k +: 8];
      for (int b = 0; b < BYTES_PER_DIV; b++) begin
        rnd  = next_random();
        // ss 3 selects nothing, fold it to 0
        ss   = (rnd[1:0] == 2'd3) ? 2'd0 : rnd[1:0];
        tx_a = rnd[15:8];
        write_reg(SPI_BASE + REG_SPI_CTRL, {16'd0, div, 5'd0, ss, 1'b1});
        rises0 = sck_rises;
        write_reg(SPI_BASE + REG_SPI_TX, {24'd0, tx_a});
        wait_busy(1'b1);
        // only the chosen select low mid-transfer
        record($sformatf("spi_ss_div%0d_byte%0d", div, b),
               32'(3'b111 & ~(3'b001 << ss)), 32'({spi_ss2, spi_ss1, spi_ss}));
        // drivers on while enabled, miso stays an input
        record($sformatf("spi_tri_div%0d_byte%0d", div, b), 32'b00010,
               32'({spi_sck_t, spi_io0_t, spi_ss_t, spi_io1_t, spi_io1_o}));
        wait_busy(1'b0);
        // one rising sck per bit
        record($sformatf("spi_sck_rises_div%0d_byte%0d", div, b), 32'd8,
               32'(sck_rises - rises0));
        read_reg(SPI_BASE + REG_SPI_RX, rdata);
        record($sformatf("spi_rx_div%0d_byte%0d", div, b), spi_rx_expect(tx_a), rdata);
      end
    end

    // second tx write lands mid-transfer
    rnd  = next_random();
    tx_a = rnd[7:0];
    tx_b = ~rnd[7:0];
    write_reg(SPI_BASE + REG_SPI_CTRL, {16'd0, 8'(BUSY_DIV), 5'd0, 2'd1, 1'b1});
    write_reg(SPI_BASE + REG_SPI_TX, {24'd0, tx_a});
    wait_busy(1'b1);
    write_reg(SPI_BASE + REG_SPI_TX, {24'd0, tx_b});
    wait_busy(1'b0);
    read_reg(SPI_BASE + REG_SPI_RX, rdata);
    record("spi_busy_write_rx", spi_rx_expect(tx_a), rdata);
    read_reg(SPI_BASE + REG_SPI_TX, rdata);
    record("spi_busy_write_tx_kept", {24'd0, tx_a}, rdata);
    // no second transfer started
    read_reg(SPI_BASE + REG_SPI_STAT, rdata);
    record("spi_busy_write_idle", 32'd0, rdata);
    tests_done = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking and end of run
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare
    string       name;
    logic [31:0] exp_v;
    logic [31:0] act_v;
    logic        finished;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      while (name_q.size() != 0) begin
        name  = name_q.pop_front();
        exp_v = exp_q.pop_front();
        act_v = act_q.pop_front();
        assert (act_v === exp_v) begin
          $display("[PASS] %s", name);
          pass_cnt++;
        end else begin
          $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
          fail_cnt++;
        end
      end
      finished = tests_done && (name_q.size() == 0);
    end
    $display("tests: %0d passed, %0d failed, %0d bus errors", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // hard limit on the whole run
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/pl_pkg.sv
hdl/ps_system.sv
hdl/gpio_regs.sv
hdl/spi_regs.sv
hdl/spi_master.sv
hdl/pl_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_top -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
exit 0
